// File: fetch_bus_ctrl.sv
/*
 * instruction bus master of the prefetch buffer
 * one outstanding request, stale responses dropped after a redirect
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_bus_ctrl #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           req_i,
  input  logic                           pc_set_i,
  input  logic [fetch_pkg::XLEN-1:0]     fetch_addr_n_i,
  input  logic [$clog2(FifoDepth+1)-1:0] fifo_cnt_i,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]     instr_rdata_i,
  input  logic                           instr_err_i,
  output logic                           instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]     instr_addr_o,
  output logic                           wr_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     wr_rdata_o,
  output logic [fetch_pkg::XLEN-1:0]     wr_addr_o,
  output logic                           wr_err_o,
  output logic                           busy_o
);

  localparam int unsigned AW   = fetch_pkg::XLEN;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic          active_q;
  logic          out_q;
  logic          discard_q;
  logic [AW-1:0] addr_q;
  logic [AW-1:0] out_addr_q;
  logic          room;
  logic          gnt_fire;

  // space for one more word once the outstanding slot is free
  assign room     = fifo_cnt_i < CntW'(FifoDepth);
  assign gnt_fire = instr_req_o & instr_gnt_i;

  ////////////////////
  // request side
  ////////////////////

  // no fetching before the first redirect, and never two in flight
  assign instr_req_o  = active_q & req_i & ~out_q & room;
  assign instr_addr_o = addr_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q  <= 1'b0;
      out_q     <= 1'b0;
      discard_q <= 1'b0;
      addr_q    <= '0;
    end else begin
      if (pc_set_i) begin
        active_q <= 1'b1;
      end
      // redirect target is word aligned, otherwise step past the granted word
      if (pc_set_i) begin
        addr_q <= {fetch_addr_n_i[AW-1:2], 2'b00};
      end else if (gnt_fire) begin
        addr_q <= addr_q + AW'(fetch_pkg::WORD_OFFS);
      end
      // response pending after a grant, retired by rvalid
      if (gnt_fire) begin
        out_q <= 1'b1;
      end else if (instr_rvalid_i) begin
        out_q <= 1'b0;
      end
      // a redirect orphans whatever is in flight, including a same cycle grant
      if (pc_set_i) begin
        discard_q <= (out_q & ~instr_rvalid_i) | gnt_fire;
      end else if (instr_rvalid_i) begin
        discard_q <= 1'b0;
      end
    end
  end

  // address of the word the next rvalid returns
  always_ff @(posedge clk_i) begin
    if (gnt_fire) begin
      out_addr_q <= addr_q;
    end
  end

  ////////////////////
  // response side
  ////////////////////

  // responses arriving with a redirect belong to the old stream
  assign wr_valid_o = instr_rvalid_i & ~discard_q & ~pc_set_i;
  assign wr_rdata_o = instr_rdata_i;
  assign wr_addr_o  = out_addr_q;
  assign wr_err_o   = instr_err_i;

  assign busy_o = instr_req_o | out_q;

  // address presented to the bus is known
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> !$isunknown(instr_addr_o))
    else $error("unknown fetch address on request");

  // the bus returns only what was granted
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> out_q)
    else $error("rvalid without outstanding request");

endmodule

`default_nettype wire

// File: fetch_fifo.sv
/*
 * small circular buffer of fetched words with their address and error bit
 * write to read takes one cycle, flush empties it on a redirect
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_fifo #(
  parameter int unsigned FifoDepth = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           flush_i,
  input  logic                           wr_valid_i,
  input  logic [fetch_pkg::XLEN-1:0]     wr_rdata_i,
  input  logic [fetch_pkg::XLEN-1:0]     wr_addr_i,
  input  logic                           wr_err_i,
  input  logic                           rd_ready_i,
  output logic                           rd_valid_o,
  output logic [fetch_pkg::XLEN-1:0]     rd_rdata_o,
  output logic [fetch_pkg::XLEN-1:0]     rd_addr_o,
  output logic                           rd_err_o,
  output logic [$clog2(FifoDepth+1)-1:0] cnt_o
);

  localparam int unsigned AW   = fetch_pkg::XLEN;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);
  localparam int unsigned PtrW = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;

  logic [AW-1:0]   rdata_q [FifoDepth];
  logic [AW-1:0]   addr_q  [FifoDepth];
  logic            err_q   [FifoDepth];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  // depth need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(FifoDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // flush drops both the head and any incoming word
  assign push = wr_valid_i & ~flush_i;
  assign pop  = rd_valid_o & rd_ready_i & ~flush_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      rdata_q[wr_ptr_q] <= wr_rdata_i;
      addr_q[wr_ptr_q]  <= wr_addr_i;
      err_q[wr_ptr_q]   <= wr_err_i;
    end
  end

  // head of the queue
  assign rd_valid_o = (cnt_q != '0);
  assign rd_rdata_o = rdata_q[rd_ptr_q];
  assign rd_addr_o  = addr_q[rd_ptr_q];
  assign rd_err_o   = err_q[rd_ptr_q];
  assign cnt_o      = cnt_q;

  // the bus controller only requests when a slot is free
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (wr_valid_i && !flush_i) |-> (cnt_q < CntW'(FifoDepth)))
    else $error("write into full fetch fifo");

endmodule

`default_nettype wire

// File: fetch_pkg.sv
/*
 * shared types and constants for the instruction fetch stage
 * referenced by scoped name from the fetch modules and the testbench
 */
`default_nettype none

package fetch_pkg;

  ////////////////////
  // widths
  ////////////////////

  // address and instruction word width
  localparam int unsigned XLEN        = 32;
  // boot_addr and mtvec are 256 byte aligned
  localparam int unsigned VEC_ALIGN_W = 8;
  // vectored interrupt id
  localparam int unsigned IRQ_ID_W    = 5;
  // word fetches only, no compressed support
  localparam int unsigned WORD_OFFS   = 4;

  ////////////////////
  // select encodings
  ////////////////////

  // source of the next fetch address on a redirect
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target when PC_EXC is selected
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

`default_nettype wire

// File: fetch_target_mux.sv
/*
 * next fetch address selection for redirects
 * computes the exception/debug target and raises the mtvec init pulse on boot
 */
`timescale 1ns/10ps
`default_nettype none

module fetch_target_mux #(
  parameter logic [fetch_pkg::XLEN-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [fetch_pkg::XLEN-1:0] DmExceptionAddr = 32'h1A110808
) (
  input  logic                          pc_set_i,
  input  fetch_pkg::pc_sel_e            pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e        exc_pc_mux_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0] irq_id_i,
  input  logic [fetch_pkg::XLEN-1:0]    boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0]    branch_target_ex_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_depc_i,
  input  logic [fetch_pkg::XLEN-1:0]    csr_mtvec_i,
  output logic [fetch_pkg::XLEN-1:0]    fetch_addr_n_o,
  output logic                          csr_mtvec_init_o
);

  localparam int unsigned AW = fetch_pkg::XLEN;
  localparam int unsigned VW = fetch_pkg::VEC_ALIGN_W;
  localparam int unsigned IW = fetch_pkg::IRQ_ID_W;

  logic [AW-1:0] mtvec_base;
  logic [AW-1:0] irq_offs;
  logic [AW-1:0] exc_pc;

  // vector table base, low bits are mode bits in mtvec
  assign mtvec_base = {csr_mtvec_i[AW-1:VW], {VW{1'b0}}};
  // one word per interrupt line
  assign irq_offs   = {{(AW-IW-2){1'b0}}, irq_id_i, 2'b00};

  always_comb begin : exc_pc_mux
    case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      fetch_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base + irq_offs;
      fetch_pkg::EXC_PC_DBD:     exc_pc = DmHaltAddr;
      fetch_pkg::EXC_PC_DBG_EXC: exc_pc = DmExceptionAddr;
      default:                   exc_pc = mtvec_base;
    endcase
  end

  always_comb begin : fetch_addr_mux
    case (pc_mux_i)
      fetch_pkg::PC_BOOT: fetch_addr_n_o = {boot_addr_i[AW-1:VW], {VW{1'b0}}};
      fetch_pkg::PC_JUMP: fetch_addr_n_o = branch_target_ex_i;
      // trap handler or debug entry
      fetch_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      fetch_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      fetch_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      default:            fetch_addr_n_o = {boot_addr_i[AW-1:VW], {VW{1'b0}}};
    endcase
  end

  // csr file loads mtvec from boot_addr on the boot redirect
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == fetch_pkg::PC_BOOT);

  // redirect inputs settle before the end of the time step
  always_comb begin : sel_checks
    if (pc_set_i) begin
      assert final (!$isunknown(pc_mux_i) && !$isunknown(exc_pc_mux_i))
        else $error("redirect with unknown pc select");
      if (pc_mux_i == fetch_pkg::PC_BOOT) begin
        assert final (boot_addr_i[VW-1:0] == '0)
          else $error("boot address not 256 byte aligned");
      end
    end
  end

endmodule

`default_nettype wire

// File: if_id_reg.sv
/*
 * IF-ID pipeline register
 * captures the fifo head when ID is ready, valid holds until cleared by ID
 */
`timescale 1ns/10ps
`default_nettype none

module if_id_reg (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       fetch_valid_i,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata_i,
  input  logic [fetch_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                       fetch_err_i,
  input  logic                       pmp_err_if_i,
  input  logic                       id_in_ready_i,
  input  logic                       pc_set_i,
  input  logic                       instr_valid_clear_i,
  output logic                       fetch_ready_o,
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_alu_id_o,
  output logic                       instr_fetch_err_o,
  output logic [fetch_pkg::XLEN-1:0] pc_id_o
);

  logic capture;
  logic valid_d;
  logic valid_q;
  logic new_q;

  // fifo pops whenever ID takes a word
  assign fetch_ready_o = id_in_ready_i;
  assign capture       = fetch_valid_i & id_in_ready_i;

  // a redirect in the capture cycle squashes the word, new still marks it
  assign valid_d = (capture & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      new_q   <= capture;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

  // payload, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (capture) begin
      instr_rdata_id_o     <= fetch_rdata_i;
      // second copy to split decoder and ALU fan-out
      instr_rdata_alu_id_o <= fetch_rdata_i;
      // bus error of the word or PMP denial of its address
      instr_fetch_err_o    <= fetch_err_i | pmp_err_if_i;
      pc_id_o              <= fetch_addr_i;
    end
  end

endmodule

`default_nettype wire

// File: if_stage.f
fetch_pkg.sv
fetch_target_mux.sv
fetch_bus_ctrl.sv
fetch_fifo.sv
if_id_reg.sv
if_stage.sv
tb_if_stage.sv

// File: if_stage.sv
/*
 * instruction fetch stage top level
 * target mux, bus controller, fetch fifo and IF-ID register wired together
 */
`timescale 1ns/10ps
`default_nettype none

module if_stage #(
  parameter logic [fetch_pkg::XLEN-1:0] DmHaltAddr      = 32'h1A110800,
  parameter logic [fetch_pkg::XLEN-1:0] DmExceptionAddr = 32'h1A110808,
  parameter int unsigned                FifoDepth       = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic [fetch_pkg::XLEN-1:0]     boot_addr_i,
  input  logic                           req_i,
  // instruction bus
  output logic                           instr_req_o,
  output logic [fetch_pkg::XLEN-1:0]     instr_addr_o,
  input  logic                           instr_gnt_i,
  input  logic                           instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0]     instr_rdata_i,
  input  logic                           instr_err_i,
  // toward ID
  output logic                           instr_valid_id_o,
  output logic                           instr_new_id_o,
  output logic [fetch_pkg::XLEN-1:0]     instr_rdata_id_o,
  output logic [fetch_pkg::XLEN-1:0]     instr_rdata_alu_id_o,
  output logic                           instr_fetch_err_o,
  output logic [fetch_pkg::XLEN-1:0]     pc_if_o,
  output logic [fetch_pkg::XLEN-1:0]     pc_id_o,
  input  logic                           pmp_err_if_i,
  // control from ID and the controller
  input  logic                           instr_valid_clear_i,
  input  logic                           pc_set_i,
  input  fetch_pkg::pc_sel_e             pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e         exc_pc_mux_i,
  input  logic [fetch_pkg::IRQ_ID_W-1:0] exc_irq_id_i,
  input  logic [fetch_pkg::XLEN-1:0]     branch_target_ex_i,
  // csrs
  input  logic [fetch_pkg::XLEN-1:0]     csr_mepc_i,
  input  logic [fetch_pkg::XLEN-1:0]     csr_depc_i,
  input  logic [fetch_pkg::XLEN-1:0]     csr_mtvec_i,
  output logic                           csr_mtvec_init_o,
  input  logic                           id_in_ready_i,
  output logic                           if_busy_o
);

  localparam int unsigned AW   = fetch_pkg::XLEN;
  localparam int unsigned CntW = $clog2(FifoDepth + 1);

  logic [AW-1:0]   fetch_addr_n;
  // bus controller to fifo
  logic            wr_valid;
  logic [AW-1:0]   wr_rdata;
  logic [AW-1:0]   wr_addr;
  logic            wr_err;
  logic [CntW-1:0] fifo_cnt;
  // fifo head to IF-ID
  logic            fetch_valid;
  logic            fetch_ready;
  logic [AW-1:0]   fetch_rdata;
  logic [AW-1:0]   fetch_addr;
  logic            fetch_err;

  fetch_target_mux #(
    .DmHaltAddr      (DmHaltAddr),
    .DmExceptionAddr (DmExceptionAddr)
  ) u_target_mux (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .irq_id_i           (exc_irq_id_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .fetch_addr_n_o     (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  fetch_bus_ctrl #(
    .FifoDepth (FifoDepth)
  ) u_bus_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .pc_set_i       (pc_set_i),
    .fetch_addr_n_i (fetch_addr_n),
    .fifo_cnt_i     (fifo_cnt),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .wr_valid_o     (wr_valid),
    .wr_rdata_o     (wr_rdata),
    .wr_addr_o      (wr_addr),
    .wr_err_o       (wr_err),
    .busy_o         (if_busy_o)
  );

  // redirect empties the buffered words
  fetch_fifo #(
    .FifoDepth (FifoDepth)
  ) u_fifo (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .flush_i    (pc_set_i),
    .wr_valid_i (wr_valid),
    .wr_rdata_i (wr_rdata),
    .wr_addr_i  (wr_addr),
    .wr_err_i   (wr_err),
    .rd_ready_i (fetch_ready),
    .rd_valid_o (fetch_valid),
    .rd_rdata_o (fetch_rdata),
    .rd_addr_o  (fetch_addr),
    .rd_err_o   (fetch_err),
    .cnt_o      (fifo_cnt)
  );

  if_id_reg u_if_id_reg (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .fetch_valid_i        (fetch_valid),
    .fetch_rdata_i        (fetch_rdata),
    .fetch_addr_i         (fetch_addr),
    .fetch_err_i          (fetch_err),
    .pmp_err_if_i         (pmp_err_if_i),
    .id_in_ready_i        (id_in_ready_i),
    .pc_set_i             (pc_set_i),
    .instr_valid_clear_i  (instr_valid_clear_i),
    .fetch_ready_o        (fetch_ready),
    .instr_valid_id_o     (instr_valid_id_o),
    .instr_new_id_o       (instr_new_id_o),
    .instr_rdata_id_o     (instr_rdata_id_o),
    .instr_rdata_alu_id_o (instr_rdata_alu_id_o),
    .instr_fetch_err_o    (instr_fetch_err_o),
    .pc_id_o              (pc_id_o)
  );

  // PMP checks the address at the fifo head
  assign pc_if_o = fetch_addr;

endmodule

`default_nettype wire

// File: tb_if_stage.sv
/*
 * random testbench for the instruction fetch stage
 * bus memory model with random grant and rvalid latency, reference model of the
 * prefetch buffer and IF-ID register, checked every cycle
 */
`timescale 1ns/10ps
`default_nettype none

module tb_if_stage;

  localparam int          CLK_HALF     = 2;
  localparam int          RESET_CYCLES = 8;
  localparam int          FIFO_DEPTH   = 2;
  localparam int          NUM_INSTR    = 500;
  // loose bound on cycles per delivered instruction
  localparam int          WORST_CYCLES = 64;
  localparam int          TIMEOUT_NS   = (RESET_CYCLES + NUM_INSTR * WORST_CYCLES) * 2 * CLK_HALF;
  localparam int          BOOT_CYCLE   = 3;
  localparam logic [31:0] DM_HALT      = 32'h1A110800;
  localparam logic [31:0] DM_EXC       = 32'h1A110808;
  localparam logic [31:0] BOOT         = 32'h0000_8000;
  localparam logic [31:0] DATA_KEY     = 32'h5A3C_96E1;

  logic                           clk_i;
  logic                           rst_ni;
  logic [31:0]                    boot_addr_i;
  logic                           req_i;
  logic                           instr_req_o;
  logic [31:0]                    instr_addr_o;
  logic                           instr_gnt_i;
  logic                           instr_rvalid_i;
  logic [31:0]                    instr_rdata_i;
  logic                           instr_err_i;
  logic                           instr_valid_id_o;
  logic                           instr_new_id_o;
  logic [31:0]                    instr_rdata_id_o;
  logic [31:0]                    instr_rdata_alu_id_o;
  logic                           instr_fetch_err_o;
  logic [31:0]                    pc_if_o;
  logic [31:0]                    pc_id_o;
  logic                           pmp_err_if_i;
  logic                           instr_valid_clear_i;
  logic                           pc_set_i;
  fetch_pkg::pc_sel_e             pc_mux_i;
  fetch_pkg::exc_pc_sel_e         exc_pc_mux_i;
  logic [fetch_pkg::IRQ_ID_W-1:0] exc_irq_id_i;
  logic [31:0]                    branch_target_ex_i;
  logic [31:0]                    csr_mepc_i;
  logic [31:0]                    csr_depc_i;
  logic [31:0]                    csr_mtvec_i;
  logic                           csr_mtvec_init_o;
  logic                           id_in_ready_i;
  logic                           if_busy_o;

  ////////////////////
  // reference model state
  ////////////////////

  integer      seed;
  // words the prefetch fifo should hold, oldest first
  logic [31:0] mq_addr[$];
  logic        mq_err[$];
  logic        active;
  // bus transaction in flight
  logic        pend;
  logic [31:0] pend_addr;
  int          pend_epoch;
  int          pend_delay;
  // bumped on every redirect, older responses are stale
  int          epoch;
  logic [31:0] req_pc;
  logic        exp_valid;
  logic        cap_valid;
  logic [31:0] cap_addr;
  logic        cap_err;
  int          n_captured;
  int          cycle;

  if_stage #(
    .DmHaltAddr      (DM_HALT),
    .DmExceptionAddr (DM_EXC),
    .FifoDepth       (FIFO_DEPTH)
  ) u_if_stage (
    .clk_i                (clk_i),
    .rst_ni               (rst_ni),
    .boot_addr_i          (boot_addr_i),
    .req_i                (req_i),
    .instr_req_o          (instr_req_o),
    .instr_addr_o         (instr_addr_o),
    .instr_gnt_i          (instr_gnt_i),
    .instr_rvalid_i       (instr_rvalid_i),
    .instr_rdata_i        (instr_rdata_i),
    .instr_err_i          (instr_err_i),
    .instr_valid_id_o     (instr_valid_id_o),
    .instr_new_id_o       (instr_new_id_o),
    .instr_rdata_id_o     (instr_rdata_id_o),
    .instr_rdata_alu_id_o (instr_rdata_alu_id_o),
    .instr_fetch_err_o    (instr_fetch_err_o),
    .pc_if_o              (pc_if_o),
    .pc_id_o              (pc_id_o),
    .pmp_err_if_i         (pmp_err_if_i),
    .instr_valid_clear_i  (instr_valid_clear_i),
    .pc_set_i             (pc_set_i),
    .pc_mux_i             (pc_mux_i),
    .exc_pc_mux_i         (exc_pc_mux_i),
    .exc_irq_id_i         (exc_irq_id_i),
    .branch_target_ex_i   (branch_target_ex_i),
    .csr_mepc_i           (csr_mepc_i),
    .csr_depc_i           (csr_depc_i),
    .csr_mtvec_i          (csr_mtvec_i),
    .csr_mtvec_init_o     (csr_mtvec_init_o),
    .id_in_ready_i        (id_in_ready_i),
    .if_busy_o            (if_busy_o)
  );

  initial begin : clock_gen
    clk_i = 1'b0;
    forever #(CLK_HALF) clk_i = ~clk_i;
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    abort_run("instruction stream stalled, timeout reached");
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
    abort_run($sformatf("[FAIL] %s got 0x%08h expected 0x%08h", name, got, exp));
  endtask

  // true with a probability of pct percent
  function automatic logic roll(input int pct);
    int r;
    r = $random(seed);
    return ($unsigned(r) % 100) < pct;
  endfunction

  function automatic logic [31:0] rand_word();
    return $random(seed);
  endfunction

  // redirect target from the fetch rules, word aligned
  function automatic logic [31:0] redirect_target();
    logic [31:0] base;
    logic [31:0] exc;
    logic [31:0] tgt;
    base = csr_mtvec_i & ~32'hFF;
    case (exc_pc_mux_i)
      fetch_pkg::EXC_PC_EXC: exc = base;
      fetch_pkg::EXC_PC_IRQ: exc = base + 32'(exc_irq_id_i) * 32'd4;
      fetch_pkg::EXC_PC_DBD: exc = DM_HALT;
      default:               exc = DM_EXC;
    endcase
    case (pc_mux_i)
      fetch_pkg::PC_BOOT: tgt = boot_addr_i & ~32'hFF;
      fetch_pkg::PC_JUMP: tgt = branch_target_ex_i;
      fetch_pkg::PC_EXC:  tgt = exc;
      fetch_pkg::PC_ERET: tgt = csr_mepc_i;
      default:            tgt = csr_depc_i;
    endcase
    return tgt & ~32'h3;
  endfunction

  ////////////////////
  // stimulus, driven on the falling edge
  ////////////////////

  task automatic drive_inputs();
    int sel;
    // memory answers once its random latency has run out
    if (pend && pend_delay == 0) begin
      instr_rvalid_i = 1'b1;
      instr_rdata_i  = pend_addr ^ DATA_KEY;
      instr_err_i    = roll(5);
    end else begin
      instr_rvalid_i = 1'b0;
      // garbage on the idle data lines
      instr_rdata_i  = rand_word();
      instr_err_i    = roll(50);
      if (pend) begin
        pend_delay--;
      end
    end
    instr_gnt_i         = roll(60);
    req_i               = roll(95);
    id_in_ready_i       = roll(70);
    instr_valid_clear_i = roll(30);
    pmp_err_if_i        = roll(5);
    // redirect operands change every cycle
    sel                 = rand_word() % 5;
    pc_mux_i            = fetch_pkg::pc_sel_e'(sel);
    exc_pc_mux_i        = fetch_pkg::exc_pc_sel_e'(rand_word() % 4);
    exc_irq_id_i        = rand_word() % 32;
    branch_target_ex_i  = rand_word() & ~32'h3;
    csr_mepc_i          = rand_word() & ~32'h3;
    csr_depc_i          = rand_word() & ~32'h3;
    csr_mtvec_i         = rand_word();
    if (cycle == BOOT_CYCLE) begin
      pc_set_i = 1'b1;
      pc_mux_i = fetch_pkg::PC_BOOT;
    end else begin
      // random redirects once the boot word has reached ID
      pc_set_i = (n_captured > 0) && roll(4);
    end
  endtask

  ////////////////////
  // model step for the coming rising edge
  ////////////////////

  task automatic model_edge();
    logic exp_req;
    logic exp_init;
    logic grant;
    logic written;
    logic capture;
    exp_req  = active && req_i && !pend && (mq_addr.size() < FIFO_DEPTH);
    exp_init = pc_set_i && (pc_mux_i == fetch_pkg::PC_BOOT);
    // fifo words plus the outstanding one never exceed the depth
    assert (!(instr_req_o && (mq_addr.size() + (pend ? 1 : 0) >= FIFO_DEPTH)))
      else abort_run("instruction request issued while the prefetch buffer is full");
    assert (instr_req_o === exp_req)
      else mismatch("instr_req_o", instr_req_o, exp_req);
    if (exp_req) begin
      assert (instr_addr_o === req_pc)
        else mismatch("instr_addr_o", instr_addr_o, req_pc);
    end
    assert (if_busy_o === (exp_req || pend))
      else mismatch("if_busy_o", if_busy_o, exp_req || pend);
    assert (csr_mtvec_init_o === exp_init)
      else mismatch("csr_mtvec_init_o", csr_mtvec_init_o, exp_init);
    // PMP looks at the address of the fifo head
    if (mq_addr.size() > 0) begin
      assert (pc_if_o === mq_addr[0])
        else mismatch("pc_if_o", pc_if_o, mq_addr[0]);
    end

    grant   = exp_req && instr_gnt_i;
    written = instr_rvalid_i && !pc_set_i && (pend_epoch == epoch);
    if (instr_rvalid_i) begin
      pend = 1'b0;
    end
    // IF-ID takes the fifo head whenever ID is ready
    capture   = (mq_addr.size() > 0) && id_in_ready_i;
    cap_valid = capture;
    if (capture) begin
      cap_addr = mq_addr[0];
      cap_err  = mq_err[0] | pmp_err_if_i;
    end
    exp_valid = (capture && !pc_set_i) || (exp_valid && !instr_valid_clear_i);
    if (pc_set_i) begin
      mq_addr.delete();
      mq_err.delete();
    end else begin
      if (capture) begin
        void'(mq_addr.pop_front());
        void'(mq_err.pop_front());
      end
      if (written) begin
        mq_addr.push_back(pend_addr);
        mq_err.push_back(instr_err_i);
      end
    end
    if (grant) begin
      pend       = 1'b1;
      pend_addr  = req_pc;
      pend_epoch = epoch;
      pend_delay = rand_word() % 4;
    end
    if (pc_set_i) begin
      epoch++;
      active = 1'b1;
      req_pc = redirect_target();
    end else if (grant) begin
      req_pc = req_pc + fetch_pkg::WORD_OFFS;
    end
    cycle++;
  endtask

  // registered outputs after the edge
  task automatic check_id_outputs();
    assert (instr_new_id_o === cap_valid)
      else mismatch("instr_new_id_o", instr_new_id_o, cap_valid);
    assert (instr_valid_id_o === exp_valid)
      else mismatch("instr_valid_id_o", instr_valid_id_o, exp_valid);
    if (cap_valid) begin
      n_captured++;
      assert (pc_id_o === cap_addr)
        else mismatch("pc_id_o", pc_id_o, cap_addr);
      assert (instr_rdata_id_o === (cap_addr ^ DATA_KEY))
        else mismatch("instr_rdata_id_o", instr_rdata_id_o, cap_addr ^ DATA_KEY);
      assert (instr_rdata_alu_id_o === (cap_addr ^ DATA_KEY))
        else mismatch("instr_rdata_alu_id_o", instr_rdata_alu_id_o, cap_addr ^ DATA_KEY);
      assert (instr_fetch_err_o === cap_err)
        else mismatch("instr_fetch_err_o", instr_fetch_err_o, cap_err);
    end
  endtask

  initial begin : stimulus
    seed                = 32'hbe85a1f5;
    rst_ni              = 1'b0;
    boot_addr_i         = BOOT;
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = '0;
    instr_err_i         = 1'b0;
    pmp_err_if_i        = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = fetch_pkg::PC_BOOT;
    exc_pc_mux_i        = fetch_pkg::EXC_PC_EXC;
    exc_irq_id_i        = '0;
    branch_target_ex_i  = '0;
    csr_mepc_i          = '0;
    csr_depc_i          = '0;
    csr_mtvec_i         = '0;
    id_in_ready_i       = 1'b0;
    active              = 1'b0;
    pend                = 1'b0;
    pend_addr           = '0;
    pend_epoch          = 0;
    pend_delay          = 0;
    epoch               = 0;
    req_pc              = '0;
    exp_valid           = 1'b0;
    cap_valid           = 1'b0;
    cap_addr            = '0;
    cap_err             = 1'b0;
    n_captured          = 0;
    cycle               = 0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    while (n_captured < NUM_INSTR) begin
      drive_inputs();
      // let the combinational outputs settle before sampling
      #1;
      model_edge();
      @(negedge clk_i);
      check_id_outputs();
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

`default_nettype wire
